/* include/ram_settings.svh */
// Single-port RAM settings
// Word width, depth and the macro split used by the generic 1p wrapper

`ifndef RAM_SETTINGS_SVH
`define RAM_SETTINGS_SVH

// Caller-facing word width in bits
`define RAM_WIDTH 39

// Total words seen by the caller
`define RAM_DEPTH 1024

// Words per hard macro
`define RAM_BANK_DEPTH 256

// Macro count follows from the two depths
`define RAM_NUM_BANKS ((`RAM_DEPTH) / (`RAM_BANK_DEPTH))

// Data bits covered by one write mask bit
// A value of 1 gives true bit-write masking
`define RAM_DBPM 1

`endif

/* hw/ram_1p_pkg.sv */
// Single-port RAM package
// Address views and the per-macro request word for the 1024x39 wrapper

`include "ram_settings.svh"

package ram_1p_pkg;

  // Address widths derived from the macro split
  localparam int RAM_ROW_W  = $clog2(`RAM_BANK_DEPTH); // Row inside one macro
  localparam int RAM_BANK_W = $clog2(`RAM_NUM_BANKS);  // Macro select
  localparam int RAM_AW     = RAM_BANK_W + RAM_ROW_W;  // Caller address

  // Data word type that also carries the active-low bit enables
  typedef logic [`RAM_WIDTH-1:0] ram_data_t;

  // Address split into macro select over macro row
  typedef struct packed {
    logic [RAM_BANK_W-1:0] bank; // Upper bits pick the macro
    logic [RAM_ROW_W-1:0]  row;  // Lower bits go to the macro
  } ram_addr_split_t;

  // Same address word read flat or as bank/row
  typedef union packed {
    logic [RAM_AW-1:0] word;  // Flat word index from the caller
    ram_addr_split_t   split; // Bank view used by the decoder
  } ram_addr_u;

  // 88-bit request for one macro
  typedef struct packed {
    logic                 ren;   // Read enable
    logic                 wen;   // Write enable
    logic [RAM_ROW_W-1:0] row;   // Macro row
    ram_data_t            wdata; // Write data
    ram_data_t            wbeb;  // Bit write enable, 0 writes the bit
  } ram_bank_req_t;

  // Idle macro request with no enables and every bit masked
  localparam ram_bank_req_t RAM_BANK_REQ_IDLE = '{
    ren:   1'b0,
    wen:   1'b0,
    row:   '0,
    wdata: '0,
    wbeb:  '1
  };

endpackage

/* hw/ram_bank_decode.sv */
// Bank decoder for the single-port RAM
// Splits one caller request into per-macro requests, inverting the mask
// into the macro's active-low bit write enable

`timescale 1ns/1ps

`include "ram_settings.svh"

module ram_bank_decode import ram_1p_pkg::*; (
  input  logic                                clk_i,       // Assertion clock only
  input  logic                                rst_n_i,     // Assertion reset only

  input  logic                                req_i,       // Access strobe
  input  logic                                write_i,     // High for write
  input  ram_addr_u                           addr_i,      // Caller address
  input  logic [`RAM_WIDTH-1:0]               wdata_i,     // Write data
  input  logic [`RAM_WIDTH-1:0]               wmask_i,     // Active-high mask

  output ram_bank_req_t [`RAM_NUM_BANKS-1:0]  bank_req_o,  // One request per macro
  output logic [RAM_BANK_W-1:0]               bank_idx_o,  // Addressed macro
  output logic                                rd_strobe_o  // Read issued this cycle
);

  logic rd_req; // Read this cycle
  logic wr_req; // Write this cycle

  assign rd_req = req_i & ~write_i;
  assign wr_req = req_i & write_i;

  // Bank view of the address steers everything
  assign bank_idx_o  = addr_i.split.bank;
  assign rd_strobe_o = rd_req;

  // Only the addressed macro sees enables
  always_comb begin
    for (int b = 0; b < `RAM_NUM_BANKS; b++) begin
      bank_req_o[b] = RAM_BANK_REQ_IDLE; // Idle unless selected
      if (addr_i.split.bank == RAM_BANK_W'(b)) begin
        bank_req_o[b].ren   = rd_req;
        bank_req_o[b].wen   = wr_req;
        bank_req_o[b].row   = addr_i.split.row;
        bank_req_o[b].wdata = wdata_i;
        bank_req_o[b].wbeb  = ~wmask_i;      // Macro writes where the bit is 0
      end
    end
  end

  // Caller mask must respect the mask granularity on writes
  // Partial groups would leave a macro word half written
  for (genvar g = 0; g < `RAM_WIDTH / `RAM_DBPM; g++) begin : g_mask_chk
    a_mask_group: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      wr_req |->
        wmask_i[g*`RAM_DBPM +: `RAM_DBPM] inside
          {{`RAM_DBPM{1'b1}}, {`RAM_DBPM{1'b0}}}
    ) else $error("Write mask group %0d is partially set", g);
  end

  // An unknown strobe would corrupt macro state and the bank register
  a_req_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(req_i)
  ) else $error("Request strobe is unknown");

endmodule

/* hw/sram_macro_be.sv */
// Byte-enable SRAM macro model, 256 x 39
// Behavioral stand-in for the hard memory block: registered read,
// write with active-low per-bit enables, output holds when not read

`timescale 1ns/1ps

`include "ram_settings.svh"

module sram_macro_be import ram_1p_pkg::*; (
  input  logic                  clk_i, // Macro clock
  input  ram_bank_req_t         req_i, // Enables, row, data and bit enables
  output logic [`RAM_WIDTH-1:0] q_o    // Read data, valid one cycle after ren
);

  // Storage, no reset, contents undefined until written
  ram_data_t mem [`RAM_BANK_DEPTH];

  // Write path
  always_ff @(posedge clk_i) begin
    if (req_i.wen) begin
      // Keep bits whose enable is high, take new data where it is low
      mem[req_i.row] <= (mem[req_i.row] & req_i.wbeb) |
                        (req_i.wdata & ~req_i.wbeb);
    end
  end

  // Read path, q_o holds between reads
  always_ff @(posedge clk_i) begin
    if (req_i.ren) begin
      q_o <= mem[req_i.row]; // Registered read port
    end
  end

  // Single port, so a read and a write never share a cycle
  a_ren_wen_excl: assert property (
    @(posedge clk_i)
    req_i.ren |-> !req_i.wen
  ) else $error("Macro read and write enables high together");

endmodule

/* hw/ram_rdata_mux.sv */
// Read data multiplexer for the single-port RAM
// Remembers which macro each read went to and returns that macro's q,
// so a following request to another bank cannot steer the output

`timescale 1ns/1ps

`include "ram_settings.svh"

module ram_rdata_mux import ram_1p_pkg::*; (
  input  logic                                    clk_i,       // Clock
  input  logic                                    rst_n_i,     // Sync reset, active low

  input  logic                                    rd_strobe_i, // Read issued this cycle
  input  logic [RAM_BANK_W-1:0]                   bank_idx_i,  // Bank of this request
  input  logic [`RAM_NUM_BANKS-1:0][`RAM_WIDTH-1:0] bank_q_i,  // Macro outputs

  output logic [`RAM_WIDTH-1:0]                   rdata_o      // Selected read data
);

  logic [RAM_BANK_W-1:0] bank_sel_q; // Bank of the last read

  // Bank register follows the read strobe only
  // Writes and idle cycles leave it alone so rdata_o holds
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bank_sel_q <= '0;                  // Bank 0 after reset
    end else if (rd_strobe_i) begin
      bank_sel_q <= bank_idx_i;          // Lines up with macro q next cycle
    end
  end

  // Macro q and bank register change on the same edge
  assign rdata_o = bank_q_i[bank_sel_q];

endmodule

/* hw/prim_generic_ram_1p.sv */
// Generic single-port RAM, 1024 x 39
// Maps the generic request onto four 256-word bit-write macros:
// decoder picks a macro, the macros store, the read mux returns the
// addressed word one cycle after the request

`timescale 1ns/1ps

`include "ram_settings.svh"

module prim_generic_ram_1p import ram_1p_pkg::*; (
  input  logic                  clk_i,   // Clock
  input  logic                  rst_n_i, // Sync reset, active low

  input  logic                  req_i,   // Access strobe, one per cycle
  input  logic                  write_i, // High for write, low for read
  input  logic [RAM_AW-1:0]     addr_i,  // Word address
  input  logic [`RAM_WIDTH-1:0] wdata_i, // Write data
  input  logic [`RAM_WIDTH-1:0] wmask_i, // Bit mask, 1 writes the bit
  output logic [`RAM_WIDTH-1:0] rdata_o  // Read data, one cycle after req_i
);

  ram_addr_u                                addr;      // Flat address as union
  ram_bank_req_t [`RAM_NUM_BANKS-1:0]       bank_req;  // Decoder to macros
  logic [`RAM_NUM_BANKS-1:0][`RAM_WIDTH-1:0] bank_q;   // Macros to mux
  logic [RAM_BANK_W-1:0]                    bank_idx;  // Addressed bank
  logic                                     rd_strobe; // Read this cycle

  // Caller address enters as a flat word index
  assign addr.word = addr_i;

  // Request decode
  ram_bank_decode u_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .write_i     (write_i),
    .addr_i      (addr),
    .wdata_i     (wdata_i),
    .wmask_i     (wmask_i),
    .bank_req_o  (bank_req),
    .bank_idx_o  (bank_idx),
    .rd_strobe_o (rd_strobe)
  );

  // Macro array, one per bank
  for (genvar b = 0; b < `RAM_NUM_BANKS; b++) begin : g_bank
    sram_macro_be u_sram (
      .clk_i (clk_i),
      .req_i (bank_req[b]), // Idle unless addressed
      .q_o   (bank_q[b])
    );
  end

  // Read data return
  ram_rdata_mux u_rdata_mux (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rd_strobe_i (rd_strobe),
    .bank_idx_i  (bank_idx),
    .bank_q_i    (bank_q),
    .rdata_o     (rdata_o)
  );

endmodule

/* verif/ram_1p_checker.sv */
// Read data checker for the single-port RAM testbench
// Mirrors every write into a shadow memory and compares rdata after each read

`timescale 1ns/1ps

`include "ram_settings.svh"

module ram_1p_checker import ram_1p_pkg::*; #(
  parameter int NAME_W = 128 // Case name, packed characters
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,      // DUT request strobe
  input  logic                  write_i,    // DUT write level
  input  logic [RAM_AW-1:0]     addr_i,     // DUT address
  input  logic [`RAM_WIDTH-1:0] wdata_i,    // DUT write data
  input  logic [`RAM_WIDTH-1:0] wmask_i,    // DUT write mask
  input  logic [`RAM_WIDTH-1:0] rdata_i,    // DUT read data
  input  logic                  exp_use_i,  // Use exp_data_i instead of the shadow
  input  logic [`RAM_WIDTH-1:0] exp_data_i, // Expected value from the case file
  input  logic                  hold_chk_i, // Check rdata with no read issued
  input  logic [NAME_W-1:0]     name_i,     // Name of the current case
  output int                    pass_cnt_o,
  output int                    fail_cnt_o,
  output logic                  busy_o      // A compare is still pending
);

  ram_data_t         shadow [`RAM_DEPTH]; // Reference contents
  logic              chk_pend;            // Compare at the next falling edge
  ram_data_t         chk_exp;
  logic [NAME_W-1:0] chk_name;
  logic [RAM_AW-1:0] chk_addr;
  int                pass_cnt;
  int                fail_cnt;

  initial begin
    pass_cnt = 0;
    fail_cnt = 0;
  end

  // Sample the request on the edge the DUT uses
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      chk_pend <= 1'b0;
    end else begin
      chk_pend <= 1'b0;
      if (req_i && write_i) begin
        // Masked bits take new data, the rest keep the old word
        shadow[addr_i] <= (shadow[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
      end
      if ((req_i && !write_i) || hold_chk_i) begin
        chk_pend <= 1'b1;
        chk_name <= name_i;
        chk_addr <= addr_i;
        chk_exp  <= exp_use_i ? exp_data_i : shadow[addr_i]; // Sees writes of earlier cycles
      end
    end
  end

  // rdata settles after the edge, compare in the middle of the cycle
  always @(negedge clk_i) begin
    if (chk_pend) begin
      if (rdata_i === chk_exp) begin
        pass_cnt++;
        $display("Pass  %0s addr %h data %h", chk_name, chk_addr, rdata_i);
      end else begin
        fail_cnt++;
        $display("Error %0s expected %h actual %h", chk_name, chk_exp, rdata_i);
      end
    end
  end

  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;
  assign busy_o     = chk_pend;

endmodule

/* verif/tb_ram_1p.sv */
// Testbench for the 1024x39 single-port RAM
// Runs the directed case file, then a seeded random mix of reads and writes

`timescale 1ns/1ps

`include "ram_settings.svh"

module tb_ram_1p import ram_1p_pkg::*; ();

  localparam int NAME_W       = 8 * 16; // Case name, up to 16 characters
  localparam int RESET_CYCLES = 16;
  localparam int POOL_SIZE    = 32;     // Addresses used by the random phase
  localparam int RAND_OPS     = 200;
  localparam int MAX_LINES    = 512;    // Bound on the case file loop
  localparam int DRAIN_LIMIT  = 20;     // Cycles allowed for the last compare

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  logic                  write;
  logic [RAM_AW-1:0]     addr;
  logic [`RAM_WIDTH-1:0] wdata;
  logic [`RAM_WIDTH-1:0] wmask;
  logic [`RAM_WIDTH-1:0] rdata;
  logic                  exp_use;    // Checker takes exp_data, not its shadow
  logic [`RAM_WIDTH-1:0] exp_data;
  logic                  hold_chk;   // Compare rdata with no read issued
  logic [NAME_W-1:0]     case_name;
  int                    pass_cnt;
  int                    fail_cnt;
  logic                  chk_busy;
  int                    exp_checks; // Compares the stimulus asked for
  bit                    run_err;    // Stimulus or timeout problem

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  prim_generic_ram_1p u_dut (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .req_i   (req),
    .write_i (write),
    .addr_i  (addr),
    .wdata_i (wdata),
    .wmask_i (wmask),
    .rdata_o (rdata)
  );

  ram_1p_checker #(.NAME_W(NAME_W)) u_checker (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_i      (req),
    .write_i    (write),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .wmask_i    (wmask),
    .rdata_i    (rdata),
    .exp_use_i  (exp_use),
    .exp_data_i (exp_data),
    .hold_chk_i (hold_chk),
    .name_i     (case_name),
    .pass_cnt_o (pass_cnt),
    .fail_cnt_o (fail_cnt),
    .busy_o     (chk_busy)
  );

  // One request per cycle, 1 ns after the rising edge
  task automatic drive_op(input logic [NAME_W-1:0] nm, input logic rq, input logic wr,
                          input logic hc, input logic [RAM_AW-1:0] a,
                          input logic [`RAM_WIDTH-1:0] d, input logic [`RAM_WIDTH-1:0] m,
                          input logic eu, input logic [`RAM_WIDTH-1:0] e);
    @(posedge clk);
    #1;
    case_name = nm;
    req       = rq;
    write     = wr;
    hold_chk  = hc;
    addr      = a;
    wdata     = d;
    wmask     = m;
    exp_use   = eu;
    exp_data  = e;
    if ((rq && !wr) || hc) begin
      exp_checks++;
    end
  endtask

  function automatic logic [`RAM_WIDTH-1:0] rand_word();
    logic [63:0] raw;
    raw = {$urandom(), $urandom()};
    return raw[`RAM_WIDTH-1:0];
  endfunction

  task automatic run_file_cases();
    int                    fd;
    int                    n;
    int                    lines;
    string                 line;
    logic [NAME_W-1:0]     nm;
    logic [7:0]            op;
    logic [RAM_AW-1:0]     a;
    logic [`RAM_WIDTH-1:0] d;
    logic [`RAM_WIDTH-1:0] m;
    logic [`RAM_WIDTH-1:0] e;
    fd = $fopen("verif/ram_1p_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file verif/ram_1p_cases.txt");
      run_err = 1'b1;
      return;
    end
    lines = 0;
    while (!$feof(fd) && lines < MAX_LINES) begin
      lines++;
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") begin
        continue; // Blank or comment line
      end
      nm = '0;
      n  = $sscanf(line, "%s %s %h %h %h %h", nm, op, a, d, m, e);
      if (n != 6) begin
        $display("Case file line %0d does not have six fields", lines);
        run_err = 1'b1;
        continue;
      end
      case (op)
        "W": drive_op(nm, 1'b1, 1'b1, 1'b0, a, d, m, 1'b0, '0);
        "R": drive_op(nm, 1'b1, 1'b0, 1'b0, a, '0, '0, 1'b1, e);
        "H": drive_op(nm, 1'b0, 1'b0, 1'b1, a, '0, '0, 1'b1, e); // Hold check
        "I": drive_op(nm, 1'b0, 1'b0, 1'b0, a, '0, '0, 1'b0, '0);
        default: begin
          $display("Case %0s has an unknown operation", nm);
          run_err = 1'b1;
        end
      endcase
    end
    $fclose(fd);
  endtask

  task automatic run_random();
    logic [RAM_AW-1:0] pool [POOL_SIZE];
    logic [NAME_W-1:0] nm;
    logic [RAM_AW-1:0] a;
    // Fill the pool with full writes so every random read has defined data
    for (int k = 0; k < POOL_SIZE; k++) begin
      pool[k] = RAM_AW'($urandom());
      $sformat(nm, "fill_%0d", k);
      drive_op(nm, 1'b1, 1'b1, 1'b0, pool[k], rand_word(), '1, 1'b0, '0);
    end
    for (int k = 0; k < RAND_OPS; k++) begin
      a = pool[$urandom_range(POOL_SIZE - 1)];
      $sformat(nm, "rand_%0d", k);
      if ($urandom_range(1) == 1) begin
        drive_op(nm, 1'b1, 1'b1, 1'b0, a, rand_word(), rand_word(), 1'b0, '0);
      end else begin
        drive_op(nm, 1'b1, 1'b0, 1'b0, a, '0, '0, 1'b0, '0); // Shadow gives expected
      end
    end
  endtask

  task automatic wait_checks_done();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (chk_busy && cycles < DRAIN_LIMIT);
    if (chk_busy) begin
      $display("Timed out after %0d cycles waiting for the last read compare", cycles);
      run_err = 1'b1;
    end
  endtask

  initial begin
    void'($urandom(32'hdd2f));
    rst_n      = 1'b0;
    req        = 1'b0;
    write      = 1'b0;
    addr       = '0;
    wdata      = '0;
    wmask      = '0;
    exp_use    = 1'b0;
    exp_data   = '0;
    hold_chk   = 1'b0;
    case_name  = '0;
    exp_checks = 0;
    run_err    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    run_file_cases();
    run_random();
    drive_op("idle", 1'b0, 1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
    wait_checks_done();
    if (pass_cnt + fail_cnt != exp_checks) begin
      $display("Only %0d of %0d read compares were made", pass_cnt + fail_cnt, exp_checks);
      run_err = 1'b1;
    end
    $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !run_err) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verif/ram_1p_cases.txt */
# name op addr data mask expected, values in hex, expected used by R and H only
# op: W write, R read, H check rdata holds with no request, I idle cycle
w_b0      W 010 1234567890 7fffffffff 0000000000
r_b0      R 010 0000000000 0000000000 1234567890
w_b1      W 110 2a5a5a5a5a 7fffffffff 0000000000
r_b1      R 110 0000000000 0000000000 2a5a5a5a5a
w_b2      W 210 5555555555 7fffffffff 0000000000
r_b2      R 210 0000000000 0000000000 5555555555
w_b3      W 310 7f00ff00ff 7fffffffff 0000000000
r_b3      R 310 0000000000 0000000000 7f00ff00ff
iso_w_b1  W 110 0000000000 7fffffffff 0000000000
iso_r_b0  R 010 0000000000 0000000000 1234567890
iso_r_b2  R 210 0000000000 0000000000 5555555555
iso_r_b3  R 310 0000000000 0000000000 7f00ff00ff
iso_r_b1  R 110 0000000000 0000000000 0000000000
b2b_r_b3  R 310 0000000000 0000000000 7f00ff00ff
b2b_r_b0  R 010 0000000000 0000000000 1234567890
b2b_r_b2  R 210 0000000000 0000000000 5555555555
b2b_r_b1  R 110 0000000000 0000000000 0000000000
pm_base   W 2a3 7fffffffff 7fffffffff 0000000000
pm_low    W 2a3 0000000000 00000000ff 0000000000
pm_read1  R 2a3 0000000000 0000000000 7fffffff00
pm_mid    W 2a3 1234500000 00fff00000 0000000000
pm_read2  R 2a3 0000000000 0000000000 7f345fff00
pm_single W 2a3 0000000000 4000000000 0000000000
pm_read3  R 2a3 0000000000 0000000000 3f345fff00
hold_r    R 010 0000000000 0000000000 1234567890
hold_w    W 020 3333333333 7fffffffff 0000000000
hold_w2   W 310 0000000001 000000000f 0000000000
hold_i    I 000 0000000000 0000000000 0000000000
hold_c1   H 000 0000000000 0000000000 1234567890
hold_i2   I 000 0000000000 0000000000 0000000000
hold_c2   H 000 0000000000 0000000000 1234567890
raw_r_b3  R 310 0000000000 0000000000 7f00ff00f1

/* project.f */
+incdir+include
hw/ram_1p_pkg.sv
hw/ram_bank_decode.sv
hw/sram_macro_be.sv
hw/ram_rdata_mux.sv
hw/prim_generic_ram_1p.sv
verif/ram_1p_checker.sv
verif/tb_ram_1p.sv

/* Bender.yml */
package:
  name: ram_1p

export_include_dirs:
  - include

sources:
  - target: rtl
    include_dirs:
      - include
    files:
      - hw/ram_1p_pkg.sv
      - hw/ram_bank_decode.sv
      - hw/sram_macro_be.sv
      - hw/ram_rdata_mux.sv
      - hw/prim_generic_ram_1p.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/ram_1p_checker.sv
      - verif/tb_ram_1p.sv
